/* design/game_pkg.sv */
// game rules package
// mode encoding, event pulses, rule status and score helpers
package game_pkg;

	// top-level game mode
	typedef enum logic [1:0] {
		mode_idle     = 2'd0,
		mode_classic  = 2'd1,
		mode_infinity = 2'd2,
		mode_over     = 2'd3
	} game_mode_t;

	typedef struct packed {
		logic [3:0] kill;       // one bit per enemy tank
		logic       player_hit; // player tank was hit
	} game_event_t;

	typedef struct packed {
		logic [6:0] score;  // 0..99
		logic [6:0] figure; // hp (classic) or seconds left (infinity)
		logic       over;
	} rule_status_t;

	localparam logic [6:0] score_max = 7'd99; // score saturates here

	// add one per kill bit, saturating at score_max
	function automatic logic [6:0] add_kills(input logic [6:0] score, input logic [3:0] kill);
		logic [7:0] sum;
		sum = {1'b0, score} + 8'($countones(kill));
		return (sum > {1'b0, score_max}) ? score_max : sum[6:0];
	endfunction

endpackage

/* design/display_pkg.sv */
// seven-segment display package
// segment codes, digit type and display sizes
package display_pkg;

	// active low, bit order g f e d c b a
	typedef logic [6:0] seg_code_t;

	typedef logic [3:0] digit_t; // one decimal digit

	localparam int digit_count = 4;  // digits on the board
	localparam int led_bar_len = 14; // thermometer part of led

	localparam seg_code_t seg_blank = 7'h7f; // all segments off

	// standard patterns, 0 to 9
	localparam seg_code_t seg_digits [0:9] = '{
		7'h40, // 0
		7'h79, // 1
		7'h24, // 2
		7'h30, // 3
		7'h19, // 4
		7'h12, // 5
		7'h02, // 6
		7'h78, // 7
		7'h00, // 8
		7'h10  // 9
	};

endpackage

/* design/game_mode_ctrl.sv */
// game mode controller
// start button edge detect and the idle / playing / over state machine
`timescale 1ns/1ps

module game_mode_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,         // raw button
	input  logic                 mode_sel,      // 0 classic, 1 infinity
	input  logic                 classic_over,
	input  logic                 infinity_over,
	output game_pkg::game_mode_t mode,
	output logic                 play_classic,
	output logic                 play_infinity,
	output logic                 new_game
);
	import game_pkg::*;

	logic start_q;    // sampled button
	logic start_d;    // previous sample
	logic start_rise;

	////////////////////
	// start button
	always_ff @(posedge clk) begin
		if (reset) begin
			start_q <= 1'b0;
			start_d <= 1'b0;
		end else begin
			start_q <= start;
			start_d <= start_q;
		end
	end

	assign start_rise = start_q & ~start_d;

	// only a press in idle begins a game
	assign new_game = start_rise && (mode == mode_idle);

	////////////////////
	// mode FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= mode_idle;
		end else begin
			case (mode)
				mode_idle: if (start_rise) mode <= mode_sel ? mode_infinity : mode_classic;
				mode_classic: if (classic_over) mode <= mode_over;
				mode_infinity: if (infinity_over) mode <= mode_over;
				mode_over: if (start_rise) mode <= mode_idle; // back to the title
				default: mode <= mode_idle;
			endcase
		end
	end

	assign play_classic  = (mode == mode_classic);
	assign play_infinity = (mode == mode_infinity);

	// one rule set at a time
	a_one_game: assert property (@(posedge clk) disable iff (reset)
		!(play_classic && play_infinity));

endmodule

/* design/classic_rules.sv */
// classic rule set
// kill score, player hit points and the win score
`timescale 1ns/1ps

module classic_rules #(
	parameter int start_hp  = 3,
	parameter int win_score = 20
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   play,
	input  logic                   new_game,
	input  game_pkg::game_event_t  events,
	output game_pkg::rule_status_t status
);
	import game_pkg::*;

	game_event_t ev_q;       // sampled event pulses
	logic [6:0]  score_q;
	logic [6:0]  hp_q;
	logic        over_q;
	logic [6:0]  score_next;
	logic [6:0]  hp_next;

	// pulses outside play are dropped here
	always_ff @(posedge clk) begin
		if (reset) ev_q <= '0;
		else       ev_q <= play ? events : '0;
	end

	assign score_next = add_kills(score_q, ev_q.kill);
	assign hp_next    = (ev_q.player_hit && hp_q != 7'd0) ? hp_q - 7'd1 : hp_q;

	////////////////////
	// score and hp
	always_ff @(posedge clk) begin
		if (reset) begin
			score_q <= '0;
			hp_q    <= '0;
			over_q  <= 1'b0;
		end else if (new_game) begin
			score_q <= '0;
			hp_q    <= 7'(start_hp);
			over_q  <= 1'b0;
		end else if (play && !over_q) begin // frozen once over
			score_q <= score_next;
			hp_q    <= hp_next;
			over_q  <= (hp_next == 7'd0) || (score_next >= 7'(win_score)); // dead or won
		end
	end

	assign status = '{score: score_q, figure: hp_q, over: over_q};

	a_hp_bound: assert property (@(posedge clk) disable iff (reset)
		hp_q <= 7'(start_hp));

	// over holds until the next game
	a_over_sticky: assert property (@(posedge clk) disable iff (reset)
		(play && over_q) |=> over_q);

endmodule

/* design/infinity_rules.sv */
// infinity rule set
// countdown of game seconds, kill score with a hit penalty
`timescale 1ns/1ps

module infinity_rules #(
	parameter int game_seconds     = 60,
	parameter int ticks_per_second = 100000000
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   play,
	input  logic                   new_game,
	input  game_pkg::game_event_t  events,
	output game_pkg::rule_status_t status
);
	import game_pkg::*;

	localparam int tick_w = $clog2(ticks_per_second + 1);

	game_event_t       ev_q;
	logic [tick_w-1:0] tick_cnt;
	logic              tick_done; // one second gone
	logic [6:0]        secs_q;    // seconds left
	logic [6:0]        secs_next;
	logic [6:0]        score_q;
	logic [6:0]        score_add;
	logic [6:0]        score_next;
	logic              over_q;

	always_ff @(posedge clk) begin
		if (reset) ev_q <= '0;
		else       ev_q <= play ? events : '0;
	end

	assign tick_done = (tick_cnt == tick_w'(ticks_per_second - 1));
	assign secs_next = (tick_done && secs_q != 7'd0) ? secs_q - 7'd1 : secs_q;

	// kills first, then the hit penalty, floor at zero
	assign score_add  = add_kills(score_q, ev_q.kill);
	assign score_next = (ev_q.player_hit && score_add != 7'd0) ? score_add - 7'd1 : score_add;

	////////////////////
	// timer and score
	always_ff @(posedge clk) begin
		if (reset) begin
			tick_cnt <= '0;
			secs_q   <= '0;
			score_q  <= '0;
			over_q   <= 1'b0;
		end else if (new_game) begin
			tick_cnt <= '0;
			secs_q   <= 7'(game_seconds);
			score_q  <= '0;
			over_q   <= 1'b0;
		end else if (play && !over_q) begin
			tick_cnt <= tick_done ? '0 : tick_cnt + 1'b1;
			secs_q   <= secs_next;
			score_q  <= score_next;
			over_q   <= (secs_next == 7'd0); // time is up
		end
	end

	assign status = '{score: score_q, figure: secs_q, over: over_q};

	// the clock only runs down during a game
	a_secs_down: assert property (@(posedge clk) disable iff (reset)
		play |=> (secs_q <= $past(secs_q)));

endmodule

/* design/score_display.sv */
// score display
// picks the active rule status, scans four 7-seg digits and drives the leds
`timescale 1ns/1ps

module score_display #(
	parameter int scan_div = 100000
) (
	input  logic                   clk,
	input  logic                   reset,
	input  game_pkg::game_mode_t   mode,
	input  game_pkg::rule_status_t classic_status,
	input  game_pkg::rule_status_t infinity_status,
	output logic [3:0]             an,  // active low digit enables
	output display_pkg::seg_code_t seg,
	output logic [15:0]            led
);
	import game_pkg::*;
	import display_pkg::*;

	localparam int scan_w  = $clog2(scan_div + 1);
	localparam int digit_w = $clog2(digit_count);

	logic                   last_inf;  // last game played was infinity
	logic                   show_inf;
	rule_status_t           sel;       // status on screen
	digit_t                 digits [digit_count];
	logic [scan_w-1:0]      scan_cnt;
	logic [digit_w-1:0]     digit_idx;
	logic [led_bar_len-1:0] bar;

	////////////////////
	// game select
	always_ff @(posedge clk) begin
		if (reset)                        last_inf <= 1'b0;
		else if (mode == mode_infinity)   last_inf <= 1'b1;
		else if (mode == mode_classic)    last_inf <= 1'b0;
	end

	// over screen keeps showing the finished game
	assign show_inf = (mode == mode_infinity) || (mode == mode_over && last_inf);
	assign sel      = show_inf ? infinity_status : classic_status;

	// score on the left pair, figure on the right pair
	assign digits[3] = digit_t'(sel.score / 7'd10);
	assign digits[2] = digit_t'(sel.score % 7'd10);
	assign digits[1] = digit_t'(sel.figure / 7'd10);
	assign digits[0] = digit_t'(sel.figure % 7'd10);

	always_comb begin
		for (int i = 0; i < led_bar_len; i++) begin
			bar[i] = (sel.figure > 7'(i)); // capped at the bar length
		end
	end

	////////////////////
	// digit scan
	always_ff @(posedge clk) begin
		if (reset) begin
			scan_cnt  <= '0;
			digit_idx <= '0;
		end else if (scan_cnt == scan_w'(scan_div - 1)) begin
			scan_cnt  <= '0;
			digit_idx <= (digit_idx == digit_w'(digit_count - 1)) ? '0 : digit_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// registered outputs
	always_ff @(posedge clk) begin
		if (reset || mode == mode_idle) begin // blank in idle
			an  <= '1;
			seg <= seg_blank;
			led <= '0;
		end else begin
			an  <= ~(4'b0001 << digit_idx);
			seg <= seg_digits[digits[digit_idx]];
			led <= {sel.over, show_inf, bar};
		end
	end

endmodule

/* design/tank_score_top.sv */
// tank game score top level
// mode controller, classic and infinity rule sets and the display
`timescale 1ns/1ps

module tank_score_top #(
	parameter int start_hp         = 3,
	parameter int win_score        = 20,
	parameter int game_seconds     = 60,
	parameter int ticks_per_second = 100000000,
	parameter int scan_div         = 100000
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,    // raw start button
	input  logic                   mode_sel, // 0 classic, 1 infinity
	input  game_pkg::game_event_t  events,
	output logic [3:0]             an,
	output display_pkg::seg_code_t seg,
	output logic [15:0]            led,
	output logic                   gameover
);
	import game_pkg::*;

	game_mode_t   mode;
	logic         play_classic;
	logic         play_infinity;
	logic         new_game;
	rule_status_t classic_status;
	rule_status_t infinity_status;

	////////////////////
	// mode control
	game_mode_ctrl u_game_mode_ctrl (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.mode_sel      (mode_sel),
		.classic_over  (classic_status.over),
		.infinity_over (infinity_status.over),
		.mode          (mode),
		.play_classic  (play_classic),
		.play_infinity (play_infinity),
		.new_game      (new_game)
	);

	////////////////////
	// rule sets
	classic_rules #(
		.start_hp  (start_hp),
		.win_score (win_score)
	) u_classic_rules (
		.clk      (clk),
		.reset    (reset),
		.play     (play_classic),
		.new_game (new_game),
		.events   (events),
		.status   (classic_status)
	);

	infinity_rules #(
		.game_seconds     (game_seconds),
		.ticks_per_second (ticks_per_second)
	) u_infinity_rules (
		.clk      (clk),
		.reset    (reset),
		.play     (play_infinity),
		.new_game (new_game),
		.events   (events),
		.status   (infinity_status)
	);

	////////////////////
	// seven segment and leds
	score_display #(
		.scan_div (scan_div)
	) u_score_display (
		.clk             (clk),
		.reset           (reset),
		.mode            (mode),
		.classic_status  (classic_status),
		.infinity_status (infinity_status),
		.an              (an),
		.seg             (seg),
		.led             (led)
	);

	assign gameover = (mode == mode_over);

endmodule

/* bench/tb_clock.sv */
// testbench clock and reset
// free running clock, synchronous reset held for a few cycles
`timescale 1ns/1ps

module tb_clock #(
	parameter int period       = 8,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#2 reset = 1'b0; // clear of the edge
	end

endmodule

/* bench/tb_tank_score.sv */
// tank score testbench
// runs the command list of the cases file against the DUT and checks the display
`timescale 1ns/1ps

module tb_tank_score;
	import game_pkg::*;

	localparam int start_hp         = 3;
	localparam int win_score        = 5;
	localparam int game_seconds     = 4;
	localparam int ticks_per_second = 20;
	localparam int scan_div         = 4;
	localparam int drive_delay      = 1;  // ns after the rising edge
	localparam int settle_cycles    = 4;
	localparam int scan_timeout     = 4 * 4 * scan_div; // samples, four full scans
	localparam int second_timeout   = 3 * ticks_per_second;
	localparam int reset_timeout    = 20;

	// standard 7-seg patterns, active low gfedcba
	localparam logic [6:0] seg_table [0:9] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10
	};

	logic        clk;
	logic        reset;
	logic        start;
	logic        mode_sel;
	game_event_t events;
	logic [3:0]  an;
	logic [6:0]  seg;
	logic [15:0] led;
	logic        gameover;

	int          errors;
	int          checks;
	int          timeouts;
	logic        inf_game;      // last start asked for infinity
	logic [3:0]  digit_val [4]; // decoded digits, index = an position

	tb_clock #(.period(8), .reset_cycles(2)) u_clock (.clk(clk), .reset(reset));

	tank_score_top #(
		.start_hp         (start_hp),
		.win_score        (win_score),
		.game_seconds     (game_seconds),
		.ticks_per_second (ticks_per_second),
		.scan_div         (scan_div)
	) dut (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.mode_sel (mode_sel),
		.events   (events),
		.an       (an),
		.seg      (seg),
		.led      (led),
		.gameover (gameover)
	);

	task automatic step();
		@(posedge clk);
		#(drive_delay);
	endtask

	// 15 marks a pattern that is no digit
	function automatic logic [3:0] seg_to_digit(input logic [6:0] code);
		logic [3:0] d;
		d = 4'hf;
		for (int i = 0; i < 10; i++) begin
			if (seg_table[i] == code) d = 4'(i);
		end
		return d;
	endfunction

	// over flag, infinity flag, then the figure as a bar of up to 14
	function automatic logic [15:0] expected_led(input int figure, input logic over,
			input logic inf);
		logic [13:0] bar;
		for (int i = 0; i < 14; i++) begin
			bar[i] = (figure > i);
		end
		return {over, inf, bar};
	endfunction

	////////////////////
	// stimulus
	task automatic press_start(input logic sel);
		mode_sel = sel;
		inf_game = sel;
		start    = 1'b1;
		step();
		step(); // long enough for the edge detector
		start = 1'b0;
		step();
	endtask

	task automatic pulse_events(input logic [3:0] kill, input logic hit);
		events.kill       = kill;
		events.player_hit = hit;
		step();
		events = '0; // single cycle pulse
		step();
	endtask

	// one second passes when the led bar moves
	task automatic wait_seconds(input int n);
		logic [13:0] prev;
		int          cnt;
		for (int s = 0; s < n; s++) begin
			prev = led[13:0];
			cnt  = 0;
			while (led[13:0] == prev && cnt < second_timeout) begin
				step();
				cnt++;
			end
			if (led[13:0] == prev) begin
				timeouts++;
				$display("timeout: the countdown did not move at %0t", $time);
			end
		end
	endtask

	////////////////////
	// checking
	task automatic read_digits();
		logic [3:0] seen;
		int         cnt;
		seen = '0;
		cnt  = 0;
		while (seen != 4'hf && cnt < scan_timeout) begin
			for (int i = 0; i < 4; i++) begin
				if (an == ~(4'b0001 << i)) begin // this digit is lit
					digit_val[i] = seg_to_digit(seg);
					seen[i]      = 1'b1;
				end
			end
			if (seen != 4'hf) step();
			cnt++;
		end
		if (seen != 4'hf) begin
			timeouts++;
			$display("timeout: the digit scan never showed all four digits at %0t", $time);
		end
	endtask

	task automatic check_display(input int score, input int figure, input logic over,
			input logic blank);
		int          got_score;
		int          got_figure;
		logic [15:0] exp_led;
		repeat (settle_cycles) step();
		if (blank) begin
			checks += 3;
			assert (an == 4'hf) else begin
				errors++;
				$display("error %0t: an %b, expected all ones while idle", $time, an);
			end
			assert (led == 16'h0) else begin
				errors++;
				$display("error %0t: led %h, expected 0 while idle", $time, led);
			end
			assert (gameover == 1'b0) else begin
				errors++;
				$display("error %0t: gameover set while idle", $time);
			end
		end else begin
			read_digits();
			got_score  = int'(digit_val[3]) * 10 + int'(digit_val[2]);
			got_figure = int'(digit_val[1]) * 10 + int'(digit_val[0]);
			exp_led    = expected_led(figure, over, inf_game);
			checks += 4;
			assert (got_score == score) else begin
				errors++;
				$display("error %0t: score %0d, expected %0d", $time, got_score, score);
			end
			assert (got_figure == figure) else begin
				errors++;
				$display("error %0t: figure %0d, expected %0d", $time, got_figure, figure);
			end
			assert (led == exp_led) else begin
				errors++;
				$display("error %0t: led %h, expected %h", $time, led, exp_led);
			end
			assert (gameover == over) else begin
				errors++;
				$display("error %0t: gameover %b, expected %b", $time, gameover, over);
			end
		end
	endtask

	task automatic run_command(input logic [8*128-1:0] line, input logic [63:0] cmd);
		logic [63:0] word;
		logic [3:0]  mask;
		int          n;
		int          a;
		int          b;
		int          c;
		int          d;
		n = 0;
		if (cmd == "start") begin
			n = $sscanf(line, "%s %d", word, a);
			press_start(a[0]);
		end else if (cmd == "kill") begin
			n = $sscanf(line, "%s %b", word, mask);
			pulse_events(mask, 1'b0);
		end else if (cmd == "hit") begin
			pulse_events(4'h0, 1'b1);
		end else if (cmd == "wait") begin
			n = $sscanf(line, "%s %d", word, a);
			wait_seconds(a);
		end else if (cmd == "expect") begin
			n = $sscanf(line, "%s %d %d %d %d", word, a, b, c, d);
			if (n == 5) check_display(a, b, c[0], d[0]);
			else begin
				errors++;
				$display("malformed expect line in the cases file");
			end
		end else begin
			errors++;
			$display("unknown command in the cases file: %0s", cmd);
		end
	endtask

	////////////////////
	// main sequence
	initial begin : main
		int               fd;
		int               n;
		int               cnt;
		logic [8*128-1:0] line;
		logic [63:0]      cmd;
		start    = 1'b0;
		mode_sel = 1'b0;
		events   = '0;
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		inf_game = 1'b0;
		cnt      = 0;
		while (reset !== 1'b0 && cnt < reset_timeout) begin
			step();
			cnt++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		fd = $fopen("bench/score_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open bench/score_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				cmd  = '0;
				n    = $fgets(line, fd);
				if (n > 0) n = $sscanf(line, "%s", cmd);
				if (n > 0 && cmd != "#") run_command(line, cmd); // skip comments
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* bench/score_cases.txt */
# start <0 classic, 1 infinity> | kill <mask> | hit | wait <seconds>
# expect <score> <figure> <over> <blank>
expect 0 0 0 1
start 0
expect 0 3 0 0
kill 0111
expect 3 3 0 0
kill 0100
expect 4 3 0 0
hit
hit
hit
expect 4 0 1 0
kill 1111
hit
expect 4 0 1 0
start 0
expect 0 0 0 1
start 0
expect 0 3 0 0
kill 0011
kill 0111
expect 5 3 1 0
start 1
expect 0 0 0 1
start 1
hit
expect 0 4 0 0
wait 1
kill 0011
expect 2 3 0 0
wait 1
hit
expect 1 2 0 0
wait 2
expect 1 0 1 0
start 0
expect 0 0 0 1

/* all.f */
design/game_pkg.sv
design/display_pkg.sv
design/game_mode_ctrl.sv
design/classic_rules.sv
design/infinity_rules.sv
design/score_display.sv
design/tank_score_top.sv
bench/tb_clock.sv
bench/tb_tank_score.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tank_score
RTL_TOP   ?= tank_score_top
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
